// File: src/deconv_pkg.sv
package deconv_pkg;

    ////////////////////
    // pixel widths
    ////////////////////

    localparam int PIX_WIDTH = 16;   // one input pixel

    // signed input pixel, first arrival is index 0 of a column
    typedef logic signed [PIX_WIDTH-1:0] pix_t;

    // products and overlap-add sums, wrap at double width
    typedef logic signed [2*PIX_WIDTH-1:0] acc_t;

    ////////////////////
    // engine states
    ////////////////////

    typedef enum logic [1:0] {
        IDLE,    // waiting for a column
        ACCUM,   // one feature pixel per cycle
        OUTPUT   // sums complete, handed to the output stage
    } eng_state_e;

endpackage

// File: src/col_pair_if.sv
`timescale 1ns/1ps

// feature column + weight column handed to the deconv engine
interface col_pair_if #(
    parameter int SIZE_OF_FEATURE = 2,
    parameter int SIZE_OF_WEIGHT  = 3
);

    logic                                   start;          // one-cycle strobe
    deconv_pkg::pix_t [SIZE_OF_FEATURE-1:0] feat_col;       // held until next start
    deconv_pkg::pix_t [SIZE_OF_WEIGHT-1:0]  weight_col;     // last committed column
    logic                                   weight_loaded;  // sticky after first commit

    modport feat_src (
        output start,
        output feat_col
    );

    modport weight_src (
        output weight_col,
        output weight_loaded
    );

    modport engine (
        input start,
        input feat_col,
        input weight_col,
        input weight_loaded
    );

endinterface

// File: src/weight_col_loader.sv
`timescale 1ns/1ps

module weight_col_loader #(
    parameter int SIZE_OF_WEIGHT = 3
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_weight_valid,
    input  deconv_pkg::pix_t     i_weight_pix,
    col_pair_if.weight_src       o_pair
);

    localparam int WIDX_W = (SIZE_OF_WEIGHT > 1) ? $clog2(SIZE_OF_WEIGHT) : 1;

    logic [WIDX_W-1:0]                     w_cnt;       // pixels staged so far
    logic                                  last_pix;
    deconv_pkg::pix_t [SIZE_OF_WEIGHT-1:0] stage_col;
    deconv_pkg::pix_t [SIZE_OF_WEIGHT-1:0] stage_next;

    assign last_pix = i_weight_valid && (w_cnt == WIDX_W'(SIZE_OF_WEIGHT - 1));

    // staged column with the incoming pixel dropped in
    always_comb
    begin
        stage_next        = stage_col;
        stage_next[w_cnt] = i_weight_pix;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            w_cnt                <= '0;
            o_pair.weight_loaded <= 1'b0;
        end
        else if (i_weight_valid)
        begin
            if (last_pix)
            begin
                w_cnt                <= '0;
                o_pair.weight_loaded <= 1'b1;
            end
            else
                w_cnt <= w_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_weight_valid)
            stage_col <= stage_next;
        if (last_pix)
            o_pair.weight_col <= stage_next;   // commit full column only
    end

    a_cnt_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        w_cnt < SIZE_OF_WEIGHT)
        else $error("weight pixel count out of range");

endmodule

// File: src/feature_pingpong.sv
`timescale 1ns/1ps

module feature_pingpong #(
    parameter int SIZE_OF_FEATURE = 2
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_feature_valid,
    input  deconv_pkg::pix_t     i_feature_pix,
    col_pair_if.feat_src         o_pair
);

    localparam int FIDX_W = (SIZE_OF_FEATURE > 1) ? $clog2(SIZE_OF_FEATURE) : 1;

    ////////////////////
    // bank storage
    ////////////////////

    deconv_pkg::pix_t [SIZE_OF_FEATURE-1:0] bank [2];
    logic                                   fill_sel;   // bank being written
    logic [FIDX_W-1:0]                      pix_idx;
    logic                                   last_pix;

    assign last_pix = i_feature_valid && (pix_idx == FIDX_W'(SIZE_OF_FEATURE - 1));

    // the other bank holds the most recently completed column
    assign o_pair.feat_col = bank[~fill_sel];

    always_ff @(posedge i_clk)
    begin
        if (i_feature_valid)
            bank[fill_sel][pix_idx] <= i_feature_pix;
    end

    ////////////////////
    // fill control
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            fill_sel     <= 1'b0;
            pix_idx      <= '0;
            o_pair.start <= 1'b0;
        end
        else
        begin
            o_pair.start <= last_pix;   // same cycle the banks swap
            if (i_feature_valid)
            begin
                if (last_pix)
                begin
                    pix_idx  <= '0;
                    fill_sel <= ~fill_sel;
                end
                else
                    pix_idx <= pix_idx + 1'b1;
            end
        end
    end

    a_idx_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        pix_idx < SIZE_OF_FEATURE)
        else $error("feature pixel index out of range");

    a_start_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pair.start |=> !o_pair.start)
        else $error("start held for two cycles");

endmodule

// File: src/deconv_col_engine.sv
`timescale 1ns/1ps

module deconv_col_engine #(
    parameter  int SIZE_OF_FEATURE = 2,
    parameter  int SIZE_OF_WEIGHT  = 3,
    parameter  int STRIDE          = 1,
    localparam int N_PIX_OUT       = SIZE_OF_FEATURE * SIZE_OF_WEIGHT
                                     - (SIZE_OF_WEIGHT - STRIDE) * (SIZE_OF_FEATURE - 1)
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    col_pair_if.engine                       i_pair,
    output logic                             o_valid,
    output deconv_pkg::acc_t [N_PIX_OUT-1:0] o_deconv_col
);

    localparam int FIDX_W = (SIZE_OF_FEATURE > 1) ? $clog2(SIZE_OF_FEATURE) : 1;

    deconv_pkg::eng_state_e                 state;
    logic [FIDX_W-1:0]                      feat_idx;   // next feature pixel in ACCUM
    logic                                   take;       // column accepted
    logic                                   res_pend;   // res_q holds a finished column
    deconv_pkg::pix_t [SIZE_OF_FEATURE-1:0] feat_q;
    deconv_pkg::pix_t [SIZE_OF_WEIGHT-1:0]  weight_q;
    deconv_pkg::acc_t [N_PIX_OUT-1:0]       acc;
    deconv_pkg::acc_t [N_PIX_OUT-1:0]       acc_next;
    deconv_pkg::acc_t [N_PIX_OUT-1:0]       res_q;
    deconv_pkg::pix_t                       cur_pix;
    deconv_pkg::pix_t [SIZE_OF_WEIGHT-1:0]  cur_w;
    int                                     base_pos;

    // OUTPUT frees the accumulators, so a new column may land there too
    assign take = i_pair.start && i_pair.weight_loaded && (state != deconv_pkg::ACCUM);

    ////////////////////
    // multiply + overlap-add
    ////////////////////

    always_comb
    begin
        if (state == deconv_pkg::ACCUM)
        begin
            cur_pix  = feat_q[feat_idx];
            cur_w    = weight_q;
            base_pos = int'(feat_idx) * STRIDE;
            acc_next = acc;
        end
        else
        begin
            // pixel 0 straight off the interface, sums start from zero
            cur_pix  = i_pair.feat_col[0];
            cur_w    = i_pair.weight_col;
            base_pos = 0;
            acc_next = '0;
        end
        for (int j = 0; j < SIZE_OF_WEIGHT; j++)
        begin
            acc_next[base_pos + j] = acc_next[base_pos + j]
                + deconv_pkg::acc_t'(cur_pix) * deconv_pkg::acc_t'(cur_w[j]);
        end
    end

    ////////////////////
    // control FSM
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state    <= deconv_pkg::IDLE;
            feat_idx <= '0;
            res_pend <= 1'b0;
            o_valid  <= 1'b0;
        end
        else
        begin
            res_pend <= (state == deconv_pkg::OUTPUT);
            o_valid  <= res_pend;
            case (state)
                deconv_pkg::ACCUM:
                begin
                    if (feat_idx == FIDX_W'(SIZE_OF_FEATURE - 1))
                        state <= deconv_pkg::OUTPUT;
                    feat_idx <= feat_idx + 1'b1;
                end
                default:   // IDLE or OUTPUT
                begin
                    if (take)
                    begin
                        state    <= (SIZE_OF_FEATURE > 1) ? deconv_pkg::ACCUM
                                                          : deconv_pkg::OUTPUT;
                        feat_idx <= FIDX_W'(1);
                    end
                    else
                        state <= deconv_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (take || state == deconv_pkg::ACCUM)
            acc <= acc_next;
        if (take)
        begin
            feat_q   <= i_pair.feat_col;
            weight_q <= i_pair.weight_col;   // weights as of the start cycle
        end
        if (state == deconv_pkg::OUTPUT)
            res_q <= acc;
        if (res_pend)
            o_deconv_col <= res_q;
    end

    // feature side must not outrun the accumulation
    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pair.start |-> state != deconv_pkg::ACCUM)
        else $error("start arrived during ACCUM");

    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        take |-> ##(SIZE_OF_FEATURE + 2) o_valid)
        else $error("accepted column missed its output slot");

endmodule

// File: src/deconv_top.sv
`timescale 1ns/1ps

module deconv_top #(
    parameter  int SIZE_OF_FEATURE = 2,
    parameter  int SIZE_OF_WEIGHT  = 3,
    parameter  int STRIDE          = 1,   // 1 .. SIZE_OF_WEIGHT
    localparam int N_PIX_OUT       = SIZE_OF_FEATURE * SIZE_OF_WEIGHT
                                     - (SIZE_OF_WEIGHT - STRIDE) * (SIZE_OF_FEATURE - 1)
) (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    // weight pixel stream
    input  logic                             i_weight_valid,
    input  deconv_pkg::pix_t                 i_weight_pix,
    // feature pixel stream
    input  logic                             i_feature_valid,
    input  deconv_pkg::pix_t                 i_feature_pix,
    // one deconvolved column per pulse
    output logic                             o_valid,
    output deconv_pkg::acc_t [N_PIX_OUT-1:0] o_deconv_col
);

    col_pair_if #(
        .SIZE_OF_FEATURE (SIZE_OF_FEATURE),
        .SIZE_OF_WEIGHT  (SIZE_OF_WEIGHT)
    ) pair_if ();

    ////////////////////
    // column sources
    ////////////////////

    weight_col_loader #(
        .SIZE_OF_WEIGHT (SIZE_OF_WEIGHT)
    ) weight_col_loader_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_weight_valid (i_weight_valid),
        .i_weight_pix   (i_weight_pix),
        .o_pair         (pair_if.weight_src)
    );

    feature_pingpong #(
        .SIZE_OF_FEATURE (SIZE_OF_FEATURE)
    ) feature_pingpong_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_feature_valid (i_feature_valid),
        .i_feature_pix   (i_feature_pix),
        .o_pair          (pair_if.feat_src)
    );

    ////////////////////
    // operator
    ////////////////////

    deconv_col_engine #(
        .SIZE_OF_FEATURE (SIZE_OF_FEATURE),
        .SIZE_OF_WEIGHT  (SIZE_OF_WEIGHT),
        .STRIDE          (STRIDE)
    ) deconv_col_engine_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pair       (pair_if.engine),
        .o_valid      (o_valid),
        .o_deconv_col (o_deconv_col)
    );

endmodule

// File: sim/tb_deconv_top.sv
`timescale 1ns/1ps

module tb_deconv_top;

    localparam int SF          = 2;     // DUT defaults
    localparam int SW          = 3;
    localparam int STRIDE      = 1;
    localparam int N_PIX_OUT   = SF * SW - (SW - STRIDE) * (SF - 1);
    localparam int CLK_PERIOD  = 20;
    localparam int STIM_CYCLES = 480;   // upper bound over all phases
    localparam int MARGIN      = 100;

    typedef deconv_pkg::acc_t [N_PIX_OUT-1:0] col_t;

    logic             i_clk = 1'b0;
    logic             i_rst_n;
    logic             i_weight_valid;
    deconv_pkg::pix_t i_weight_pix;
    logic             i_feature_valid;
    deconv_pkg::pix_t i_feature_pix;
    logic             o_valid;
    col_t             o_deconv_col;

    deconv_top deconv_top_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_weight_valid  (i_weight_valid),
        .i_weight_pix    (i_weight_pix),
        .i_feature_valid (i_feature_valid),
        .i_feature_pix   (i_feature_pix),
        .o_valid         (o_valid),
        .o_deconv_col    (o_deconv_col)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    ////////////////////
    // reference model
    ////////////////////

    deconv_pkg::pix_t [SW-1:0] w_model;    // committed weight column
    deconv_pkg::pix_t [SW-1:0] w_stage;
    deconv_pkg::pix_t [SF-1:0] f_stage;
    int          w_cnt        = 0;
    int          f_cnt        = 0;
    bit          w_loaded     = 1'b0;
    int          edge_no      = 0;
    int          due_q [$];                // edge after which o_valid must be high
    col_t        col_q [$];
    logic        exp_valid    = 1'b0;
    col_t        exp_col      = '0;
    int          value_errs   = 0;
    int          valid_errs   = 0;
    int          cols_checked = 0;
    logic [31:0] lfsr         = 32'hb582_826d;

    // sum of f[i] * w[j] over all i * STRIDE + j == k
    function automatic col_t deconv_ref(input deconv_pkg::pix_t [SF-1:0] f,
                                        input deconv_pkg::pix_t [SW-1:0] w);
        col_t r;
        r = '0;
        for (int k = 0; k < N_PIX_OUT; k++)
            for (int i = 0; i < SF; i++)
                for (int j = 0; j < SW; j++)
                    if (i * STRIDE + j == k)
                        r[k] = r[k] + deconv_pkg::acc_t'(deconv_pkg::pix_t'(f[i]))
                                    * deconv_pkg::acc_t'(deconv_pkg::pix_t'(w[j]));
        return r;
    endfunction

    always @(posedge i_clk)
    begin
        edge_no = edge_no + 1;
        if (i_rst_n)
        begin
            // weights first, a column finishing on this edge is already used
            if (i_weight_valid)
            begin
                w_stage[w_cnt] = i_weight_pix;
                w_cnt          = w_cnt + 1;
                if (w_cnt == SW)
                begin
                    w_model  = w_stage;
                    w_loaded = 1'b1;
                    w_cnt    = 0;
                end
            end
            if (i_feature_valid)
            begin
                f_stage[f_cnt] = i_feature_pix;
                f_cnt          = f_cnt + 1;
                if (f_cnt == SF)
                begin
                    f_cnt = 0;
                    if (w_loaded)   // no weights yet, column dropped
                    begin
                        due_q.push_back(edge_no + SF + 2);
                        col_q.push_back(deconv_ref(f_stage, w_model));
                    end
                end
            end
        end
        if (due_q.size() != 0 && due_q[0] == edge_no)
        begin
            exp_valid <= 1'b1;
            exp_col   <= col_q.pop_front();
            void'(due_q.pop_front());
            cols_checked = cols_checked + 1;
        end
        else
            exp_valid <= 1'b0;
    end

    ////////////////////
    // checks
    ////////////////////

    a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |=> !o_valid)
        else
        begin
            valid_errs++;
            $display("CHECK FAILED @%0t: o_valid high during reset", $time);
        end

    a_valid_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid == exp_valid)
        else
        begin
            valid_errs++;
            $display("CHECK FAILED @%0t: o_valid is %b, expected %b", $time,
                     $sampled(o_valid), $sampled(exp_valid));
        end

    a_col_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        exp_valid |-> o_deconv_col == exp_col)
        else
        begin
            value_errs++;
            $display("CHECK FAILED @%0t: column %h, expected %h", $time,
                     $sampled(o_deconv_col), $sampled(exp_col));
        end

    ////////////////////
    // stimulus
    ////////////////////

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic deconv_pkg::pix_t rand_pix();
        logic [2:0]       sel;
        deconv_pkg::pix_t p;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0:    p = deconv_pkg::pix_t'(16'h8000);   // most negative
            3'd1:    p = deconv_pkg::pix_t'(16'h7fff);
            default: p = deconv_pkg::pix_t'(rand_bits(16));
        endcase
        return p;
    endfunction

    task automatic drive_cycle(input logic wv, input deconv_pkg::pix_t wp,
                               input logic fv, input deconv_pkg::pix_t fp);
        @(posedge i_clk);
        i_weight_valid  <= wv;
        i_weight_pix    <= wp;
        i_feature_valid <= fv;
        i_feature_pix   <= fp;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, 1'b0, '0);
    endtask

    task automatic send_weight_col();
        for (int j = 0; j < SW; j++)
            drive_cycle(1'b1, rand_pix(), 1'b0, '0);
    endtask

    task automatic send_feature_col();
        for (int i = 0; i < SF; i++)
            drive_cycle(1'b0, '0, 1'b1, rand_pix());
    endtask

    initial
    begin
        i_rst_n         = 1'b0;
        i_weight_valid  = 1'b0;
        i_weight_pix    = '0;
        i_feature_valid = 1'b0;
        i_feature_pix   = '0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // features before any weights, then a partial weight column
        repeat (2) send_feature_col();
        idle(6);
        drive_cycle(1'b1, rand_pix(), 1'b0, '0);
        drive_cycle(1'b1, rand_pix(), 1'b0, '0);
        idle(1);
        send_feature_col();
        idle(6);
        drive_cycle(1'b1, rand_pix(), 1'b0, '0);   // completes it
        idle(2);

        // single column
        send_weight_col();
        idle(2);
        send_feature_col();
        idle(8);

        // back-to-back, both banks busy
        repeat (20) send_feature_col();
        idle(6);

        // weight switching between and during feature columns
        send_feature_col();
        send_weight_col();
        send_feature_col();
        for (int c = 0; c < 6; c++)
            drive_cycle(c == 1 || c == 2, rand_pix(), 1'b1, rand_pix());
        drive_cycle(1'b1, rand_pix(), 1'b0, '0);
        send_feature_col();
        idle(6);
        for (int c = 0; c < 3; c++)
            drive_cycle(1'b1, rand_pix(), c > 0, rand_pix());   // same-edge commit
        idle(6);

        // random data and gaps
        for (int n = 0; n < 300; n++)
            drive_cycle(rand_bits(3) == 0, rand_pix(), rand_bits(1) == 1, rand_pix());
        idle(1);

        while (due_q.size() != 0)
            @(posedge i_clk);
        repeat (3) @(posedge i_clk);

        $display("errors: %0d column value, %0d o_valid timing; columns checked: %0d",
                 value_errs, valid_errs, cols_checked);
        if (value_errs + valid_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #((STIM_CYCLES + MARGIN) * CLK_PERIOD);
        $display("run timed out after %0d cycles", STIM_CYCLES + MARGIN);
        $display("test failed");
        $finish;
    end

endmodule

// File: list.f
src/deconv_pkg.sv
src/col_pair_if.sv
src/weight_col_loader.sv
src/feature_pingpong.sv
src/deconv_col_engine.sv
src/deconv_top.sv
sim/tb_deconv_top.sv
